//--- design/scope_pkg.sv
// Scope package with the sizes, register map, capture states and bus structs of the capture engine
`default_nettype none

package scope_pkg;

    // Capture geometry
    localparam int N_CHANNELS      = 4;
    localparam int SAMPLE_WIDTH    = 16;
    localparam int DEST_WIDTH      = 8;
    localparam int CHANNEL_SAMPLES = 8;
    localparam int MEM_ADDR_WIDTH  = 8;
    localparam int CHAN_IDX_WIDTH  = $clog2(N_CHANNELS);
    localparam int FRAME_WIDTH     = $clog2(CHANNEL_SAMPLES);

    // Configuration port and timebase widths
    localparam int CFG_ADDR_WIDTH = 4;
    localparam int CFG_DATA_WIDTH = 32;
    localparam int DIV_WIDTH      = 16;

    // Register map, word addresses on the configuration port
    typedef enum logic [CFG_ADDR_WIDTH-1:0] {
        REG_CONTROL  = 4'd0,
        REG_SELECT_0 = 4'd1,
        REG_SELECT_1 = 4'd2,
        REG_SELECT_2 = 4'd3,
        REG_SELECT_3 = 4'd4,
        REG_DIVIDER  = 4'd5
    } cfg_addr_e;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_FRAME,
        CAP_WRITE,
        CAP_DONE
    } capture_state_e;

    // One beat of the tagged sample stream
    typedef struct packed {
        logic [SAMPLE_WIDTH-1:0] data;
        logic [DEST_WIDTH-1:0]   dest;
    } stream_beat_t;

    typedef struct packed {
        logic                      write;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wdata;
    } cfg_req_t;

    // One word toward the channel-major capture buffer
    typedef struct packed {
        logic [MEM_ADDR_WIDTH-1:0] addr;
        logic [SAMPLE_WIDTH-1:0]   data;
    } mem_write_t;

    typedef logic [N_CHANNELS-1:0][DEST_WIDTH-1:0]   channel_sel_t;
    typedef logic [N_CHANNELS-1:0][SAMPLE_WIDTH-1:0] channel_samples_t;

endpackage

`default_nettype wire

//--- design/scope_config_regs.sv
// Scope configuration registers on a four-phase req/ack port, holding control, selectors and divider
`default_nettype none

module scope_config_regs (
    input  wire                                        clock,
    input  wire                                        rst,
    input  wire scope_pkg::cfg_req_t                   cfg_req,
    input  wire                                        cfg_valid_req,
    output logic                                       cfg_ack,
    output logic [scope_pkg::CFG_DATA_WIDTH-1:0]       cfg_rdata,
    output logic                                       disable_capture,
    output scope_pkg::channel_sel_t                    channel_sel,
    output logic [scope_pkg::DIV_WIDTH-1:0]            divider,
    output logic                                       rearm
);

    logic                                  access;
    logic [scope_pkg::CHAN_IDX_WIDTH-1:0]  sel_idx;
    scope_pkg::cfg_addr_e                  reg_addr;

    // An access happens once per request, in the cycle the req is seen before the ack
    assign access   = cfg_valid_req && !cfg_ack;
    assign reg_addr = scope_pkg::cfg_addr_e'(cfg_req.addr);
    assign sel_idx  = scope_pkg::CHAN_IDX_WIDTH'(cfg_req.addr - scope_pkg::REG_SELECT_0);

    always_ff @(posedge clock) begin
        if (rst) begin
            cfg_ack         <= 1'b0;
            cfg_rdata       <= '0;
            disable_capture <= 1'b0;
            channel_sel     <= '0;
            divider         <= '0;
            rearm           <= 1'b0;
        end else begin
            rearm <= 1'b0;
            if (access) begin
                cfg_ack   <= 1'b1;
                cfg_rdata <= '0;
                if (cfg_req.write) begin
                    case (reg_addr)
                        scope_pkg::REG_CONTROL: begin
                            disable_capture <= cfg_req.wdata[0];
                            // Every control write restarts the capture, whatever the value
                            rearm <= 1'b1;
                        end
                        scope_pkg::REG_SELECT_0, scope_pkg::REG_SELECT_1,
                        scope_pkg::REG_SELECT_2, scope_pkg::REG_SELECT_3: begin
                            channel_sel[sel_idx] <= cfg_req.wdata[scope_pkg::DEST_WIDTH-1:0];
                        end
                        scope_pkg::REG_DIVIDER: begin
                            divider <= cfg_req.wdata[scope_pkg::DIV_WIDTH-1:0];
                        end
                        default: begin
                        end
                    endcase
                end else begin
                    // Unmapped addresses leave the read data at zero
                    case (reg_addr)
                        scope_pkg::REG_CONTROL:
                            cfg_rdata <= scope_pkg::CFG_DATA_WIDTH'(disable_capture);
                        scope_pkg::REG_SELECT_0, scope_pkg::REG_SELECT_1,
                        scope_pkg::REG_SELECT_2, scope_pkg::REG_SELECT_3:
                            cfg_rdata <= scope_pkg::CFG_DATA_WIDTH'(channel_sel[sel_idx]);
                        scope_pkg::REG_DIVIDER:
                            cfg_rdata <= scope_pkg::CFG_DATA_WIDTH'(divider);
                        default:
                            cfg_rdata <= '0;
                    endcase
                end
            end else if (!cfg_valid_req) begin
                // Return to zero once the master has released the req
                cfg_ack <= 1'b0;
            end
        end
    end

    // The ack only ever rises in answer to a request seen in the cycle before
    ack_follows_req: assert property (
        @(posedge clock) disable iff (rst) $rose(cfg_ack) |-> $past(cfg_valid_req)
    );

endmodule

`default_nettype wire

//--- design/sample_timebase.sv
// Sample timebase producing a one-cycle strobe every divider+1 cycles while enabled
`default_nettype none

module sample_timebase (
    input  wire                                 clock,
    input  wire                                 rst,
    input  wire                                 enable,
    input  wire [scope_pkg::DIV_WIDTH-1:0]      divider,
    output logic                                sample_strobe
);

    logic [scope_pkg::DIV_WIDTH-1:0] count;

    always_ff @(posedge clock) begin
        if (rst || !enable) begin
            // The count restarts from zero so the first strobe follows enable at once
            count         <= '0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= (count == '0);
            if (count == '0) begin
                // Reloading divider gives a period of divider+1 cycles
                count <= divider;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/channel_extractor.sv
// Channel extractor routing stream beats into per-channel hold slots by selector match
`default_nettype none

module channel_extractor (
    input  wire                              clock,
    input  wire                              rst,
    input  wire scope_pkg::stream_beat_t     stream_in,
    input  wire                              stream_valid,
    output logic                             stream_ready,
    input  wire scope_pkg::channel_sel_t     channel_sel,
    input  wire                              slot_take,
    output logic [scope_pkg::N_CHANNELS-1:0] slot_full,
    output scope_pkg::channel_samples_t      slot_data
);

    logic [scope_pkg::N_CHANNELS-1:0] match;
    logic                             accept;

    always_comb begin
        for (int c = 0; c < scope_pkg::N_CHANNELS; c++) begin
            match[c] = (stream_in.dest == channel_sel[c]);
        end
    end

    // A beat waits while any channel it belongs to still holds an untaken sample
    assign stream_ready = ((match & slot_full) == '0);
    assign accept       = stream_valid && stream_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            slot_full <= '0;
        end else begin
            for (int c = 0; c < scope_pkg::N_CHANNELS; c++) begin
                if (accept && match[c]) begin
                    slot_full[c] <= 1'b1;
                end else if (slot_take) begin
                    slot_full[c] <= 1'b0;
                end
            end
        end
    end

    // Beats matching no channel are accepted and simply never land in a slot
    always_ff @(posedge clock) begin
        for (int c = 0; c < scope_pkg::N_CHANNELS; c++) begin
            if (accept && match[c]) begin
                slot_data[c] <= stream_in.data;
            end
        end
    end

    // A held sample is never overwritten before the engine has taken it
    for (genvar c = 0; c < scope_pkg::N_CHANNELS; c++) begin : g_slot_check
        full_slot_held: assert property (
            @(posedge clock) disable iff (rst) slot_full[c] |=> $stable(slot_data[c])
        );
    end

endmodule

`default_nettype wire

//--- design/capture_engine.sv
// Capture engine matching strobes with full slots and writing each frame in channel order
`default_nettype none

module capture_engine (
    input  wire                                 clock,
    input  wire                                 rst,
    input  wire                                 disable_capture,
    input  wire                                 rearm,
    input  wire                                 sample_strobe,
    input  wire [scope_pkg::N_CHANNELS-1:0]     slot_full,
    input  wire scope_pkg::channel_samples_t    slot_data,
    output logic                                slot_take,
    output logic                                capture_active,
    output logic                                wr_valid,
    output scope_pkg::mem_write_t               wr_word,
    input  wire                                 wr_done,
    output logic                                dma_done
);

    scope_pkg::capture_state_e             state;
    scope_pkg::channel_samples_t           frame_buf;
    logic                                  pending;
    logic [scope_pkg::FRAME_WIDTH-1:0]     frame;
    logic [scope_pkg::CHAN_IDX_WIDTH-1:0]  chan;
    logic                                  last_chan;

    // A frame is taken once a strobe is pending and every channel holds a sample
    assign slot_take      = (state == scope_pkg::CAP_WAIT_FRAME) && pending && (&slot_full);
    assign capture_active = (state == scope_pkg::CAP_WAIT_FRAME) || (state == scope_pkg::CAP_WRITE);
    assign last_chan      = (chan == scope_pkg::CHAN_IDX_WIDTH'(scope_pkg::N_CHANNELS - 1));

    // Channel-major layout puts sample s of channel c at c*CHANNEL_SAMPLES+s
    assign wr_word.addr = scope_pkg::MEM_ADDR_WIDTH'(chan) *
                          scope_pkg::MEM_ADDR_WIDTH'(scope_pkg::CHANNEL_SAMPLES) +
                          scope_pkg::MEM_ADDR_WIDTH'(frame);
    assign wr_word.data = frame_buf[chan];

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= scope_pkg::CAP_IDLE;
            pending  <= 1'b0;
            frame    <= '0;
            chan     <= '0;
            wr_valid <= 1'b0;
            dma_done <= 1'b0;
        end else if (rearm) begin
            frame    <= '0;
            chan     <= '0;
            pending  <= 1'b0;
            wr_valid <= 1'b0;
            dma_done <= 1'b0;
            state    <= disable_capture ? scope_pkg::CAP_IDLE : scope_pkg::CAP_WAIT_FRAME;
        end else if (disable_capture) begin
            state    <= scope_pkg::CAP_IDLE;
            pending  <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            // Strobes arriving while busy merge into one pending request
            pending <= sample_strobe || (pending && !slot_take);
            case (state)
                scope_pkg::CAP_WAIT_FRAME: begin
                    if (slot_take) begin
                        chan     <= '0;
                        wr_valid <= 1'b1;
                        state    <= scope_pkg::CAP_WRITE;
                    end
                end
                scope_pkg::CAP_WRITE: begin
                    if (wr_done) begin
                        if (!last_chan) begin
                            chan <= chan + 1'b1;
                        end else begin
                            chan     <= '0;
                            wr_valid <= 1'b0;
                            if (frame == scope_pkg::FRAME_WIDTH'(scope_pkg::CHANNEL_SAMPLES - 1)) begin
                                dma_done <= 1'b1;
                                state    <= scope_pkg::CAP_DONE;
                            end else begin
                                frame <= frame + 1'b1;
                                state <= scope_pkg::CAP_WAIT_FRAME;
                            end
                        end
                    end
                end
                // Idle waits for a rearm and done holds dma_done until the next one
                default: begin
                end
            endcase
        end
    end

    // The frame copy lives in a payload register without reset
    always_ff @(posedge clock) begin
        if (slot_take) begin
            frame_buf <= slot_data;
        end
    end

    write_only_in_write_state: assert property (
        @(posedge clock) disable iff (rst) wr_valid |-> (state == scope_pkg::CAP_WRITE)
    );

endmodule

`default_nettype wire

//--- design/dma_writer.sv
// DMA writer running the four-phase req/ack write of one buffer word toward external memory
`default_nettype none

module dma_writer (
    input  wire                           clock,
    input  wire                           rst,
    input  wire                           wr_valid,
    input  wire scope_pkg::mem_write_t    wr_word,
    output logic                          wr_done,
    output logic                          mem_req,
    output scope_pkg::mem_write_t         mem_write,
    input  wire                           mem_ack
);

    logic releasing;
    logic start;

    // The word offered alongside wr_done is the one just finished, so it is not restarted
    assign start = !mem_req && !releasing && wr_valid && !wr_done;

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_req   <= 1'b0;
            releasing <= 1'b0;
            wr_done   <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (start) begin
                mem_req <= 1'b1;
            end else if (mem_req) begin
                if (mem_ack) begin
                    mem_req   <= 1'b0;
                    releasing <= 1'b1;
                end
            end else if (releasing && !mem_ack) begin
                // The handshake is complete only after the memory drops its ack
                releasing <= 1'b0;
                wr_done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            mem_write <= wr_word;
        end
    end

    // Address and data stay put for the whole request phase
    write_held_during_req: assert property (
        @(posedge clock) disable iff (rst) mem_req && $past(mem_req) |-> $stable(mem_write)
    );

endmodule

`default_nettype wire

//--- design/uscope_stream_dma.sv
// Scope stream capture top level joining registers, timebase, extractor, engine and DMA writer
`default_nettype none

module uscope_stream_dma (
    input  wire                                    clock,
    input  wire                                    rst,
    input  wire scope_pkg::cfg_req_t               cfg_req,
    input  wire                                    cfg_valid_req,
    output logic                                   cfg_ack,
    output logic [scope_pkg::CFG_DATA_WIDTH-1:0]   cfg_rdata,
    input  wire scope_pkg::stream_beat_t           stream_in,
    input  wire                                    stream_valid,
    output logic                                   stream_ready,
    output logic                                   mem_req,
    output scope_pkg::mem_write_t                  mem_write,
    input  wire                                    mem_ack,
    output logic                                   dma_done
);

    logic                              disable_capture;
    logic                              rearm;
    scope_pkg::channel_sel_t           channel_sel;
    logic [scope_pkg::DIV_WIDTH-1:0]   divider;
    logic                              sample_strobe;
    logic                              capture_active;
    logic [scope_pkg::N_CHANNELS-1:0]  slot_full;
    scope_pkg::channel_samples_t       slot_data;
    logic                              slot_take;
    logic                              wr_valid;
    scope_pkg::mem_write_t             wr_word;
    logic                              wr_done;

    scope_config_regs regs_i (
        .clock(clock), .rst(rst),
        .cfg_req(cfg_req), .cfg_valid_req(cfg_valid_req),
        .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
        .disable_capture(disable_capture), .channel_sel(channel_sel),
        .divider(divider), .rearm(rearm)
    );

    // The timebase only paces samples while a capture is under way
    sample_timebase timebase_i (
        .clock(clock), .rst(rst),
        .enable(capture_active), .divider(divider),
        .sample_strobe(sample_strobe)
    );

    channel_extractor extractor_i (
        .clock(clock), .rst(rst),
        .stream_in(stream_in), .stream_valid(stream_valid), .stream_ready(stream_ready),
        .channel_sel(channel_sel), .slot_take(slot_take),
        .slot_full(slot_full), .slot_data(slot_data)
    );

    capture_engine engine_i (
        .clock(clock), .rst(rst),
        .disable_capture(disable_capture), .rearm(rearm),
        .sample_strobe(sample_strobe),
        .slot_full(slot_full), .slot_data(slot_data), .slot_take(slot_take),
        .capture_active(capture_active),
        .wr_valid(wr_valid), .wr_word(wr_word), .wr_done(wr_done),
        .dma_done(dma_done)
    );

    dma_writer writer_i (
        .clock(clock), .rst(rst),
        .wr_valid(wr_valid), .wr_word(wr_word), .wr_done(wr_done),
        .mem_req(mem_req), .mem_write(mem_write), .mem_ack(mem_ack)
    );

endmodule

`default_nettype wire

//--- verif/tb_uscope_stream_dma.sv
// Testbench for the scope stream capture top level with register driver, stream source and memory
`default_nettype none

module tb_uscope_stream_dma;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RNG_SEED = 32'h7c52;
    localparam int BUFFER_WORDS = scope_pkg::N_CHANNELS * scope_pkg::CHANNEL_SAMPLES;
    // Three captures of 32 slow writes stay near 1000 cycles each, so this leaves a wide margin
    localparam int CYCLE_LIMIT = 20000;

    logic                                  clock = 1'b0;
    logic                                  rst;
    scope_pkg::cfg_req_t                   cfg_req;
    logic                                  cfg_valid_req;
    logic                                  cfg_ack;
    logic [scope_pkg::CFG_DATA_WIDTH-1:0]  cfg_rdata;
    scope_pkg::stream_beat_t               stream_in;
    logic                                  stream_valid;
    logic                                  stream_ready;
    logic                                  mem_req;
    scope_pkg::mem_write_t                 mem_write;
    logic                                  mem_ack;
    logic                                  dma_done;

    // Every beat the DUT accepted, in order, which is all the reference needs
    scope_pkg::stream_beat_t               beat_log[$];
    scope_pkg::channel_sel_t               sel_cfg;
    logic [scope_pkg::SAMPLE_WIDTH-1:0]    buffer_mem [0:255];
    int                                    write_capture [0:255];
    int                                    total_writes;
    int                                    writes_at_start;
    int                                    stall_cycles = 0;
    int                                    cycles = 0;
    int                                    capture_gen;
    int                                    check_capture;
    int                                    check_requests;
    int                                    checks_done;
    logic                                  stream_enable;
    logic                                  slow_memory;

    uscope_stream_dma dut_i (
        .clock(clock), .rst(rst),
        .cfg_req(cfg_req), .cfg_valid_req(cfg_valid_req),
        .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
        .stream_in(stream_in), .stream_valid(stream_valid), .stream_ready(stream_ready),
        .mem_req(mem_req), .mem_write(mem_write), .mem_ack(mem_ack),
        .dma_done(dma_done)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sample number index of a channel is the index-th accepted beat carrying its selector
    function automatic logic [31:0] expected_word(
        input scope_pkg::stream_beat_t beats[$],
        input scope_pkg::channel_sel_t sel,
        input int                      chan,
        input int                      index
    );
        int          seen;
        logic [31:0] word;
        seen = 0;
        // No such beat gives a value that no 16-bit sample can equal
        word = '1;
        foreach (beats[i]) begin
            if (beats[i].dest == sel[chan]) begin
                if (seen == index) begin
                    word = 32'(beats[i].data);
                end
                seen++;
            end
        end
        return word;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t ns: %s: got %0h, expected %0h",
                               $time, what, actual, expected));
        end
    endtask

    // One four-phase access; the ack is expected on the second falling edge after the req
    task automatic cfg_access(input logic write, input logic [scope_pkg::CFG_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clock);
        #2;
        cfg_req.write = write;
        cfg_req.addr  = addr;
        cfg_req.wdata = wdata;
        cfg_valid_req = 1'b1;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!cfg_ack);
        check_equal(32'(waited), 32'd2, "cycles from cfg req to ack");
        rdata = cfg_rdata;
        @(posedge clock);
        #2;
        cfg_valid_req = 1'b0;
        do begin
            @(negedge clock);
        end while (cfg_ack);
    endtask

    task automatic cfg_write(input logic [scope_pkg::CFG_ADDR_WIDTH-1:0] addr,
                             input logic [31:0] wdata);
        logic [31:0] unused_rdata;
        cfg_access(1'b1, addr, wdata, unused_rdata);
    endtask

    task automatic cfg_read(input logic [scope_pkg::CFG_ADDR_WIDTH-1:0] addr,
                            output logic [31:0] rdata);
        cfg_access(1'b0, addr, 32'd0, rdata);
    endtask

    // A control write with capture enabled starts a fresh buffer
    task automatic start_capture();
        capture_gen = capture_gen + 1;
        writes_at_start = total_writes;
        cfg_write(scope_pkg::REG_CONTROL, 32'd0);
        check_equal(32'(dma_done), 32'd0, "dma_done after control write");
    endtask

    task automatic wait_for_done();
        while (!dma_done) begin
            @(negedge clock);
        end
        check_equal(32'(total_writes - writes_at_start), 32'(BUFFER_WORDS),
                    "memory writes when dma_done rose");
    endtask

    task automatic check_buffer(input int capture_index);
        check_capture = capture_index;
        check_requests = check_requests + 1;
        wait (checks_done == check_requests);
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout: no verdict after %0d clock cycles", CYCLE_LIMIT));
        end
    end

    always @(negedge clock) begin
        if (!rst && stream_valid && !stream_ready) begin
            stall_cycles <= stall_cycles + 1;
        end
    end

    // Stream source offering random beats back to back, dest codes 0 to 10
    initial begin : stream_driver
        logic [31:0]                      stream_rng;
        scope_pkg::stream_beat_t          beat;
        logic [scope_pkg::N_CHANNELS-1:0] beat_match;
        logic [scope_pkg::N_CHANNELS-1:0] round_sent;
        stream_rng = RNG_SEED;
        stream_in = '0;
        stream_valid = 1'b0;
        round_sent = '0;
        wait (stream_enable);
        forever begin
            @(posedge clock);
            #2;
            // A beat for a channel that already got its sample of this frame is drawn again
            // A stalled beat would otherwise keep the other channels from ever filling
            do begin
                stream_rng = xorshift32(stream_rng);
                beat.data = stream_rng[15:0];
                beat.dest = scope_pkg::DEST_WIDTH'(stream_rng[31:16] % 16'd11);
                for (int c = 0; c < scope_pkg::N_CHANNELS; c++) begin
                    beat_match[c] = (beat.dest == sel_cfg[c]);
                end
            end while ((beat_match & round_sent) != '0);
            round_sent = round_sent | beat_match;
            if (&round_sent) begin
                round_sent = '0;
            end
            stream_in = beat;
            stream_valid = 1'b1;
            @(negedge clock);
            while (!stream_ready) begin
                @(negedge clock);
            end
            // Ready seen before the edge means the beat transfers on it
            beat_log.push_back(beat);
        end
    end

    // Memory answering each req after a random delay and storing the word by address
    initial begin : memory_model
        logic [31:0] delay_rng;
        int          delay;
        delay_rng = RNG_SEED;
        mem_ack = 1'b0;
        total_writes = 0;
        for (int a = 0; a < 256; a++) begin
            write_capture[a] = -1;
        end
        forever begin
            @(negedge clock);
            if (mem_req) begin
                delay_rng = xorshift32(delay_rng);
                delay = slow_memory ? 4 + int'(delay_rng % 32'd8) : int'(delay_rng % 32'd4);
                repeat (delay) @(posedge clock);
                @(posedge clock);
                #2;
                check_equal(32'(int'(mem_write.addr) < BUFFER_WORDS), 32'd1,
                            "write address inside buffer");
                check_equal(32'(write_capture[mem_write.addr] != capture_gen), 32'd1,
                            "single write per address in one capture");
                buffer_mem[mem_write.addr] = mem_write.data;
                write_capture[mem_write.addr] = capture_gen;
                total_writes++;
                mem_ack = 1'b1;
                while (mem_req) begin
                    @(negedge clock);
                end
                @(posedge clock);
                #2;
                mem_ack = 1'b0;
            end
        end
    end

    // Captures follow each other without losing beats, so capture k starts at sample k*8
    initial begin : buffer_checker
        int addr;
        int base;
        checks_done = 0;
        forever begin
            wait (check_requests > checks_done);
            base = check_capture * scope_pkg::CHANNEL_SAMPLES;
            for (int c = 0; c < scope_pkg::N_CHANNELS; c++) begin
                for (int s = 0; s < scope_pkg::CHANNEL_SAMPLES; s++) begin
                    addr = c * scope_pkg::CHANNEL_SAMPLES + s;
                    check_equal(32'(write_capture[addr] == capture_gen), 32'd1,
                                $sformatf("word %0d written in capture %0d", addr, check_capture));
                    check_equal(32'(buffer_mem[addr]),
                                expected_word(beat_log, sel_cfg, c, base + s),
                                $sformatf("capture %0d channel %0d sample %0d",
                                          check_capture, c, s));
                end
            end
            // Channels 0 and 3 share a selector and hold the same samples
            for (int s = 0; s < scope_pkg::CHANNEL_SAMPLES; s++) begin
                check_equal(32'(buffer_mem[s]),
                            32'(buffer_mem[(scope_pkg::N_CHANNELS - 1) *
                                           scope_pkg::CHANNEL_SAMPLES + s]),
                            $sformatf("channel 0 against channel 3 sample %0d", s));
            end
            checks_done++;
        end
    end

    initial begin : main_sequence
        logic [31:0] rdata;
        int          req_cycles;
        int          stalls_before;
        int          writes_before;
        rst = 1'b1;
        cfg_req = '0;
        cfg_valid_req = 1'b0;
        stream_enable = 1'b0;
        slow_memory = 1'b0;
        capture_gen = 0;
        check_capture = 0;
        check_requests = 0;
        writes_at_start = 0;
        sel_cfg[0] = 8'd3;
        sel_cfg[1] = 8'd7;
        sel_cfg[2] = 8'd9;
        sel_cfg[3] = 8'd3;
        repeat (4) @(posedge clock);
        #2;
        rst = 1'b0;
        @(negedge clock);
        check_equal(32'(cfg_ack), 32'd0, "cfg_ack after reset");
        check_equal(32'(mem_req), 32'd0, "mem_req after reset");
        check_equal(32'(stream_ready), 32'd1, "stream_ready after reset");
        check_equal(32'(dma_done), 32'd0, "dma_done after reset");

        // Register readback, zero out of reset, then the written values
        for (int a = int'(scope_pkg::REG_CONTROL); a <= int'(scope_pkg::REG_DIVIDER); a++) begin
            cfg_read(scope_pkg::CFG_ADDR_WIDTH'(a), rdata);
            check_equal(rdata, 32'd0, $sformatf("register %0d after reset", a));
        end
        for (int c = 0; c < scope_pkg::N_CHANNELS; c++) begin
            cfg_write(scope_pkg::CFG_ADDR_WIDTH'(int'(scope_pkg::REG_SELECT_0) + c),
                      32'(sel_cfg[c]));
        end
        cfg_write(scope_pkg::REG_DIVIDER, 32'd5);
        for (int c = 0; c < scope_pkg::N_CHANNELS; c++) begin
            cfg_read(scope_pkg::CFG_ADDR_WIDTH'(int'(scope_pkg::REG_SELECT_0) + c), rdata);
            check_equal(rdata, 32'(sel_cfg[c]), $sformatf("selector %0d readback", c));
        end
        cfg_read(scope_pkg::REG_DIVIDER, rdata);
        check_equal(rdata, 32'd5, "divider readback");
        cfg_read(4'd9, rdata);
        check_equal(rdata, 32'd0, "unmapped address readback");

        // First capture with quick acks, then a quiet window after completion
        stream_enable = 1'b1;
        start_capture();
        wait_for_done();
        check_buffer(0);
        writes_before = total_writes;
        repeat (100) @(negedge clock);
        check_equal(32'(total_writes - writes_before), 32'd0, "writes after dma_done");
        check_equal(32'(dma_done), 32'd1, "dma_done held until control write");

        // Disabled capture stays off the memory bus while the stream backs up
        cfg_write(scope_pkg::REG_CONTROL, 32'd1);
        check_equal(32'(dma_done), 32'd0, "dma_done after disable write");
        stalls_before = stall_cycles;
        req_cycles = 0;
        repeat (200) begin
            @(negedge clock);
            if (mem_req) begin
                req_cycles++;
            end
        end
        check_equal(32'(req_cycles), 32'd0, "mem_req cycles while disabled");
        check_equal(32'(stall_cycles > stalls_before), 32'd1, "stream stall while disabled");
        start_capture();
        wait_for_done();
        check_buffer(1);

        // Rearm with long ack delays
        slow_memory = 1'b1;
        start_capture();
        wait_for_done();
        check_buffer(2);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/scope_pkg.sv
design/scope_config_regs.sv
design/sample_timebase.sv
design/channel_extractor.sv
design/capture_engine.sv
design/dma_writer.sv
design/uscope_stream_dma.sv
verif/tb_uscope_stream_dma.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the capture engine testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_uscope_stream_dma \
    -f project.f \
    -o Vtb_uscope_stream_dma

if ! ./obj_dir/Vtb_uscope_stream_dma > sim.log 2>&1; then
    echo "Simulation process returned an error status"
fi
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "Test run failed, see sim.log"
exit 1
